/* Makefile */
# Tool, flags, top module and file list
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := divsqrt_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Result: pass"; \
	else \
	  echo "Result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/divsqrt_defines.svh */
`ifndef DIVSQRT_DEFINES_SVH
`define DIVSQRT_DEFINES_SVH

// Operand and result width
`define DS_DATA_W 16
// Request tag width
`define DS_TAG_W 4
// Input queue depth, also the sender's initial request credits
`define DS_REQ_DEPTH 2
// Response credits held after reset
`define DS_RSP_CREDITS 2
// Iterations per operation, one result bit each
`define DS_DIV_ITERS 16
`define DS_SQRT_ITERS 8

`endif

/* source/divsqrt_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic q_empty_i,
  input  logic last_i,
  input  logic rsp_credit_avail_i,
  output logic pop_o,
  output logic start_o,
  output logic capture_o,
  output logic fire_o
);
  import divsqrt_ctrl_pkg::*;

  ds_state_e state_q;
  ds_state_e state_d;

  // --------------------
  // Next state and outputs
  // --------------------
  always_comb begin
    state_d   = state_q;
    pop_o     = 1'b0;
    start_o   = 1'b0;
    capture_o = 1'b0;
    fire_o    = 1'b0;
    unique case (state_q)
      S_IDLE: begin
        // Pop the head and kick off the datapath in one cycle
        if (!q_empty_i) begin
          pop_o   = 1'b1;
          start_o = 1'b1;
          state_d = S_RUN;
        end
      end
      S_RUN: begin
        // Final iteration, hand the result to the hold stage
        if (last_i) begin
          capture_o = 1'b1;
          // Credit on hand, send straight from the datapath
          if (rsp_credit_avail_i) begin
            fire_o  = 1'b1;
            state_d = S_IDLE;
          end else begin
            state_d = S_HOLD;
          end
        end
      end
      S_HOLD: begin
        // Wait for the first cycle with a response credit
        if (rsp_credit_avail_i) begin
          fire_o  = 1'b1;
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  // State register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* source/divsqrt_ctrl_pkg.sv */
`default_nettype none

package divsqrt_ctrl_pkg;

  // Sequencer states
  typedef enum logic [1:0] {
    // Waiting for a queued request
    S_IDLE = 2'd0,
    // Datapath iterating
    S_RUN  = 2'd1,
    // Result captured, waiting for a response credit
    S_HOLD = 2'd2
  } ds_state_e;

endpackage

`default_nettype wire

/* source/divsqrt_datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_datapath (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    start_i,
  input  divsqrt_pkg::ds_op_e     op_i,
  input  logic [`DS_DATA_W-1:0]   operand_a_i,
  input  logic [`DS_DATA_W-1:0]   operand_b_i,
  output logic [`DS_DATA_W-1:0]   result_o,
  output logic [`DS_DATA_W-1:0]   rem_o,
  output divsqrt_pkg::ds_status_t status_o
);
  import divsqrt_pkg::*;

  localparam int unsigned W = `DS_DATA_W;
  localparam int unsigned STEPS_W = (`DS_DIV_ITERS > `DS_SQRT_ITERS) ?
                                    `DS_DIV_ITERS : `DS_SQRT_ITERS;

  // Iteration control
  ds_op_e             op_q;
  ds_status_t         status_q;
  logic [STEPS_W-1:0] todo_q;
  logic [STEPS_W-1:0] init_todo;
  // Operand shift register, divisor, quotient or root, partial remainder
  logic [W-1:0]       opa_q;
  logic [W-1:0]       opb_q;
  logic [W-1:0]       quo_q;
  logic [W-1:0]       rem_q;
  // Step sources, taken from the ports on start
  ds_op_e             src_op;
  logic [W-1:0]       src_a;
  logic [W-1:0]       src_b;
  logic [W-1:0]       src_q;
  logic [W-1:0]       src_rem;
  logic               step_en;
  logic               div_zero;
  // Trial subtraction, top bit is the borrow
  logic [W+1:0]       div_sh;
  logic [W+1:0]       div_diff;
  logic [W+1:0]       sqrt_sh;
  logic [W+1:0]       sqrt_trial;
  logic [W+1:0]       sqrt_diff;
  logic               take;
  logic [W-1:0]       next_a;
  logic [W-1:0]       next_q;
  logic [W-1:0]       next_rem;

  // One bit per remaining step, the first step runs in the start cycle
  assign init_todo = (op_i == DS_OP_DIV) ? ({STEPS_W{1'b1}} >> (STEPS_W - `DS_DIV_ITERS))
                                         : ({STEPS_W{1'b1}} >> (STEPS_W - `DS_SQRT_ITERS));
  assign div_zero = start_i && (op_i == DS_OP_DIV) && (operand_b_i == '0);
  assign step_en  = start_i || todo_q[0];

  assign src_op  = start_i ? op_i : op_q;
  assign src_a   = start_i ? operand_a_i : opa_q;
  assign src_b   = start_i ? operand_b_i : opb_q;
  assign src_q   = start_i ? '0 : quo_q;
  assign src_rem = start_i ? '0 : rem_q;

  // --------------------
  // Radix-2 step
  // --------------------
  // Division brings down one dividend bit
  assign div_sh     = {1'b0, src_rem, src_a[W-1]};
  assign div_diff   = div_sh - {2'b00, src_b};
  // Square root brings down two radicand bits, trial is 4*root+1
  assign sqrt_sh    = {src_rem, src_a[W-1:W-2]};
  assign sqrt_trial = {src_q, 2'b01};
  assign sqrt_diff  = sqrt_sh - sqrt_trial;

  always_comb begin
    if (src_op == DS_OP_DIV) begin
      take     = !div_diff[W+1];
      next_rem = take ? div_diff[W-1:0] : div_sh[W-1:0];
      next_a   = src_a << 1;
    end else begin
      take     = !sqrt_diff[W+1];
      next_rem = take ? sqrt_diff[W-1:0] : sqrt_sh[W-1:0];
      next_a   = src_a << 2;
    end
    // Result bit enters at the bottom
    next_q = {src_q[W-2:0], take};
  end

  // Payload registers hold after the final step
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      opb_q <= operand_b_i;
    end
    if (div_zero) begin
      // Forced result, no iteration
      quo_q <= '1;
      rem_q <= operand_a_i;
    end else if (step_en) begin
      opa_q <= next_a;
      quo_q <= next_q;
      rem_q <= next_rem;
    end
  end

  // Step tracking and status
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_q     <= DS_OP_DIV;
      todo_q   <= '0;
      status_q <= '0;
    end else if (start_i) begin
      op_q              <= op_i;
      todo_q            <= div_zero ? '0 : (init_todo >> 1);
      status_q.div_zero <= div_zero;
    end else if (todo_q[0]) begin
      todo_q <= todo_q >> 1;
    end
  end

  assign result_o = quo_q;
  assign rem_o    = rem_q;
  assign status_o = status_q;

endmodule

`default_nettype wire

/* source/divsqrt_iter_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_iter_counter (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  divsqrt_pkg::ds_op_e op_i,
  output logic                last_o
);
  import divsqrt_pkg::*;

  localparam int unsigned MAX_ITERS = (`DS_DIV_ITERS > `DS_SQRT_ITERS) ?
                                      `DS_DIV_ITERS : `DS_SQRT_ITERS;
  localparam int unsigned CNT_W = $clog2(MAX_ITERS + 1);

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] load_val;

  // Per-op latency, one cycle per result bit
  assign load_val = (op_i == DS_OP_DIV) ? CNT_W'(`DS_DIV_ITERS) : CNT_W'(`DS_SQRT_ITERS);

  // Load on start, count down to zero and stop there
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= load_val;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Final iteration cycle
  assign last_o = (count_q == CNT_W'(1));

endmodule

`default_nettype wire

/* source/divsqrt_pkg.sv */
`default_nettype none
`include "divsqrt_defines.svh"

package divsqrt_pkg;

  // Opcodes, one bit wide
  typedef enum logic {
    DS_OP_DIV  = 1'b0,
    DS_OP_SQRT = 1'b1
  } ds_op_e;

  // Status flags returned with each response
  typedef struct packed {
    logic div_zero;
  } ds_status_t;

  // Request as sent by the producer
  typedef struct packed {
    ds_op_e                op;
    logic [`DS_TAG_W-1:0]  tag;
    logic [`DS_DATA_W-1:0] operand_a;
    logic [`DS_DATA_W-1:0] operand_b;
  } ds_req_t;

  // Response, tag echoed back unchanged
  typedef struct packed {
    logic [`DS_TAG_W-1:0]  tag;
    logic [`DS_DATA_W-1:0] result;
    logic [`DS_DATA_W-1:0] remainder;
    ds_status_t            status;
  } ds_rsp_t;

endpackage

`default_nettype wire

/* source/divsqrt_req_queue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_req_queue (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  input  divsqrt_pkg::ds_req_t req_i,
  input  logic                 pop_i,
  output logic                 empty_o,
  output divsqrt_pkg::ds_req_t head_o,
  output logic                 req_credit_o
);
  import divsqrt_pkg::*;

  localparam int unsigned DEPTH = `DS_REQ_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Circular buffer storage
  ds_req_t          mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;
  logic             credit_q;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // Sender credits keep it from writing when full
  assign push    = req_valid_i && !full;
  assign pop     = pop_i && !empty_o;
  // Head is visible the cycle after the write
  assign head_o       = mem_q[rd_ptr_q];
  assign req_credit_o = credit_q;

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // Pointers, occupancy and the credit pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // One credit back per consumed entry, one cycle after the pop
      credit_q <= pop;
    end
  end

endmodule

`default_nettype wire

/* source/divsqrt_result_hold.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_result_hold (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    capture_i,
  input  logic                    fire_i,
  input  logic [`DS_TAG_W-1:0]    tag_i,
  input  logic [`DS_DATA_W-1:0]   result_i,
  input  logic [`DS_DATA_W-1:0]   rem_i,
  input  divsqrt_pkg::ds_status_t status_i,
  input  logic                    rsp_credit_i,
  output logic                    rsp_credit_avail_o,
  output logic                    rsp_valid_o,
  output divsqrt_pkg::ds_rsp_t    rsp_o
);
  import divsqrt_pkg::*;

  localparam int unsigned CRD_W = $clog2(`DS_RSP_CREDITS + 1);

  ds_rsp_t          fresh_rsp;
  ds_rsp_t          held_q;
  ds_rsp_t          rsp_q;
  logic             valid_q;
  logic [CRD_W-1:0] credit_q;

  // Response assembled from the datapath and the request tag
  assign fresh_rsp = '{tag: tag_i, result: result_i, remainder: rem_i, status: status_i};

  // --------------------
  // Result hold
  // --------------------
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      held_q <= fresh_rsp;
    end
    // Bypass when the result fires in its capture cycle
    if (fire_i) begin
      rsp_q <= capture_i ? fresh_rsp : held_q;
    end
  end

  // Valid pulse and response credits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      credit_q <= CRD_W'(`DS_RSP_CREDITS);
    end else begin
      valid_q <= fire_i;
      case ({rsp_credit_i, fire_i})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign rsp_credit_avail_o = (credit_q != '0);
  assign rsp_valid_o        = valid_q;
  assign rsp_o              = rsp_q;

endmodule

`default_nettype wire

/* source/divsqrt_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  input  divsqrt_pkg::ds_req_t req_i,
  output logic                 req_credit_o,
  output logic                 rsp_valid_o,
  output divsqrt_pkg::ds_rsp_t rsp_o,
  input  logic                 rsp_credit_i
);
  import divsqrt_pkg::*;

  // Queue to sequencer
  logic                  q_empty;
  logic                  q_pop;
  ds_req_t               q_head;
  // Sequencer strobes
  logic                  start;
  logic                  last;
  logic                  capture;
  logic                  fire;
  logic                  rsp_credit_avail;
  // Datapath results
  logic [`DS_DATA_W-1:0] dp_result;
  logic [`DS_DATA_W-1:0] dp_rem;
  ds_status_t            dp_status;
  // Tag of the operation in flight
  logic [`DS_TAG_W-1:0]  tag_q;

  always_ff @(posedge clk_i) begin
    if (q_pop) begin
      tag_q <= q_head.tag;
    end
  end

  // --------------------
  // Unit instances
  // --------------------
  divsqrt_req_queue i_req_queue (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .pop_i        ( q_pop        ),
    .empty_o      ( q_empty      ),
    .head_o       ( q_head       ),
    .req_credit_o ( req_credit_o )
  );

  divsqrt_ctrl_fsm i_ctrl_fsm (
    .clk_i              ( clk_i            ),
    .reset_i            ( reset_i          ),
    .q_empty_i          ( q_empty          ),
    .last_i             ( last             ),
    .rsp_credit_avail_i ( rsp_credit_avail ),
    .pop_o              ( q_pop            ),
    .start_o            ( start            ),
    .capture_o          ( capture          ),
    .fire_o             ( fire             )
  );

  // Op and operands come straight from the head in the pop cycle
  divsqrt_iter_counter i_iter_counter (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .start_i ( start     ),
    .op_i    ( q_head.op ),
    .last_o  ( last      )
  );

  divsqrt_datapath i_datapath (
    .clk_i       ( clk_i            ),
    .reset_i     ( reset_i          ),
    .start_i     ( start            ),
    .op_i        ( q_head.op        ),
    .operand_a_i ( q_head.operand_a ),
    .operand_b_i ( q_head.operand_b ),
    .result_o    ( dp_result        ),
    .rem_o       ( dp_rem           ),
    .status_o    ( dp_status        )
  );

  divsqrt_result_hold i_result_hold (
    .clk_i              ( clk_i            ),
    .reset_i            ( reset_i          ),
    .capture_i          ( capture          ),
    .fire_i             ( fire             ),
    .tag_i              ( tag_q            ),
    .result_i           ( dp_result        ),
    .rem_i              ( dp_rem           ),
    .status_i           ( dp_status        ),
    .rsp_credit_i       ( rsp_credit_i     ),
    .rsp_credit_avail_o ( rsp_credit_avail ),
    .rsp_valid_o        ( rsp_valid_o      ),
    .rsp_o              ( rsp_o            )
  );

endmodule

`default_nettype wire

/* testbench/divsqrt_chk.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_chk (
  input logic clk_i,
  input logic reset_i,
  input logic req_valid_i,
  input logic pop_i,
  input logic start_i,
  input logic capture_i,
  input logic req_credit_i,
  input logic rsp_valid_i,
  input logic rsp_credit_i
);

  // Queue occupancy as seen from the ports
  int occ_q;
  // Response credits granted and not yet used
  int crd_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      occ_q <= 0;
      crd_q <= `DS_RSP_CREDITS;
    end else begin
      occ_q <= occ_q + (req_valid_i ? 1 : 0) - (pop_i ? 1 : 0);
      crd_q <= crd_q + (rsp_credit_i ? 1 : 0) - (rsp_valid_i ? 1 : 0);
    end
  end

  // --------------------
  // Credit rules
  // --------------------
  no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> (occ_q < `DS_REQ_DEPTH))
    else $error("request arrived with the queue full");

  rsp_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> (crd_q > 0))
    else $error("response sent without a response credit");

  // --------------------
  // Handshake shape
  // --------------------
  rsp_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("response valid held longer than one cycle");

  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !(rsp_valid_i || req_credit_i || pop_i || start_i || capture_i))
    else $error("outputs or strobes active right after reset");

endmodule

bind divsqrt_top divsqrt_chk chk0 (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .req_valid_i  ( req_valid_i  ),
  .pop_i        ( q_pop        ),
  .start_i      ( start        ),
  .capture_i    ( capture      ),
  .req_credit_i ( req_credit_o ),
  .rsp_valid_i  ( rsp_valid_o  ),
  .rsp_credit_i ( rsp_credit_i )
);

`default_nettype wire

/* testbench/divsqrt_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_defines.svh"

module divsqrt_tb;
  import divsqrt_pkg::*;

  localparam int TIMEOUT = 5000;

  logic    clk_i;
  logic    reset_i;
  logic    req_valid_i;
  ds_req_t req_i;
  logic    req_credit_o;
  logic    rsp_valid_o;
  ds_rsp_t rsp_o;
  logic    rsp_credit_i;

  integer      seed;
  // Sender side
  int          req_credits;
  int          send_left;
  int unsigned send_pct;
  int          sent_total;
  int          credit_pulses;
  ds_req_t     directed[$];
  // Receiver side and reference queue
  ds_rsp_t     expected[$];
  int          rsp_credits;
  int          owed;
  int          ret_delay;
  bit          withhold;
  int          received;
  int          base;

  divsqrt_top dut0 (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_credit_o ( req_credit_o ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .rsp_credit_i ( rsp_credit_i )
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Mix of zero, all ones, small and full range operands
  function automatic logic [`DS_DATA_W-1:0] rnd_operand();
    int unsigned kind;
    kind = rnd(8);
    case (kind)
      0: return '0;
      1: return '1;
      2: return `DS_DATA_W'(rnd(16));
      default: return `DS_DATA_W'(rnd(1 << `DS_DATA_W));
    endcase
  endfunction

  function automatic ds_req_t make_req(input ds_op_e op, input int unsigned tag,
                                       input logic [`DS_DATA_W-1:0] a,
                                       input logic [`DS_DATA_W-1:0] b);
    ds_req_t req;
    req.op        = op;
    req.tag       = `DS_TAG_W'(tag);
    req.operand_a = a;
    req.operand_b = b;
    return req;
  endfunction

  function automatic ds_req_t rnd_request();
    ds_op_e op;
    op = (rnd(2) == 0) ? DS_OP_DIV : DS_OP_SQRT;
    return make_req(op, rnd(16), rnd_operand(), rnd_operand());
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic ds_rsp_t model_rsp(input ds_req_t req);
    ds_rsp_t     rsp;
    int unsigned a;
    int unsigned b;
    int unsigned root;
    a   = 32'(req.operand_a);
    b   = 32'(req.operand_b);
    rsp = '0;
    rsp.tag = req.tag;
    if (req.op == DS_OP_SQRT) begin
      // Largest root whose square fits
      root = 0;
      while ((root + 1) * (root + 1) <= a) begin
        root++;
      end
      rsp.result    = `DS_DATA_W'(root);
      rsp.remainder = `DS_DATA_W'(a - root * root);
    end else if (b == 0) begin
      rsp.result          = '1;
      rsp.remainder       = req.operand_a;
      rsp.status.div_zero = 1'b1;
    end else begin
      rsp.result    = `DS_DATA_W'(a / b);
      rsp.remainder = `DS_DATA_W'(a % b);
    end
    return rsp;
  endfunction

  task automatic value_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "value check failed");
  endtask

  task automatic timeout_error(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    $display("Simulation finished: FAIL");
    $fatal(1, "wait timed out");
  endtask

  task automatic check_response();
    ds_rsp_t exp;
    assert (expected.size() > 0) else value_error("response with nothing outstanding");
    assert (rsp_credits > 0) else value_error("response sent without a credit");
    exp = expected.pop_front();
    assert (rsp_o.tag == exp.tag)
      else value_error($sformatf("tag %0h, expected %0h", rsp_o.tag, exp.tag));
    assert (rsp_o.result == exp.result)
      else value_error($sformatf("tag %0h result %0h, expected %0h",
                                 exp.tag, rsp_o.result, exp.result));
    assert (rsp_o.remainder == exp.remainder)
      else value_error($sformatf("tag %0h remainder %0h, expected %0h",
                                 exp.tag, rsp_o.remainder, exp.remainder));
    assert (rsp_o.status == exp.status)
      else value_error($sformatf("tag %0h div_zero %0b, expected %0b",
                                 exp.tag, rsp_o.status.div_zero, exp.status.div_zero));
    rsp_credits--;
    owed++;
    received++;
  endtask

  // Credit back after a short random gap
  task automatic drive_receiver();
    rsp_credit_i = 1'b0;
    if (!withhold && owed > 0) begin
      if (ret_delay == 0) begin
        rsp_credit_i = 1'b1;
        owed--;
        rsp_credits++;
        ret_delay = rnd(4);
      end else begin
        ret_delay--;
      end
    end
  endtask

  task automatic drive_sender();
    req_valid_i = 1'b0;
    if (send_left > 0 && req_credits > 0 && rnd(100) < send_pct) begin
      if (directed.size() > 0) begin
        req_i = directed.pop_front();
      end else begin
        req_i = rnd_request();
      end
      req_valid_i = 1'b1;
      expected.push_back(model_rsp(req_i));
      req_credits--;
      send_left--;
      sent_total++;
    end
  endtask

  // One cycle, outputs sampled first and inputs driven after
  task automatic tick();
    @(negedge clk_i);
    if (req_credit_o) begin
      req_credits++;
      credit_pulses++;
      assert (req_credits <= `DS_REQ_DEPTH)
        else value_error($sformatf("request credits grew to %0d", req_credits));
    end
    if (rsp_valid_o) begin
      check_response();
    end
    drive_receiver();
    drive_sender();
  endtask

  // Everything sent, answered and credited back
  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while (send_left > 0 || expected.size() > 0 || owed > 0) begin
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        timeout_error(what);
      end
    end
  endtask

  task automatic wait_responses(input int target, input string what);
    int cycles;
    cycles = 0;
    while (received < target) begin
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        timeout_error(what);
      end
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    seed          = 44502;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    req_valid_i   = 1'b0;
    req_i         = '0;
    rsp_credit_i  = 1'b0;
    req_credits   = `DS_REQ_DEPTH;
    rsp_credits   = `DS_RSP_CREDITS;
    send_left     = 0;
    send_pct      = 100;
    sent_total    = 0;
    credit_pulses = 0;
    owed          = 0;
    ret_delay     = 0;
    withhold      = 1'b0;
    received      = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    assert (!rsp_valid_o && !req_credit_o)
      else value_error("outputs active after reset");

    // Square root and divide corner cases
    directed.push_back(make_req(DS_OP_SQRT, 0, 16'h0000, 16'h0000));
    directed.push_back(make_req(DS_OP_SQRT, 1, 16'hffff, 16'h0000));
    directed.push_back(make_req(DS_OP_SQRT, 2, 16'hfe01, 16'h0000));
    directed.push_back(make_req(DS_OP_SQRT, 3, 16'h0001, 16'h0000));
    directed.push_back(make_req(DS_OP_DIV, 4, 16'h1234, 16'h0000));
    directed.push_back(make_req(DS_OP_DIV, 5, 16'hffff, 16'h0001));
    directed.push_back(make_req(DS_OP_DIV, 6, 16'h0000, 16'h0007));
    directed.push_back(make_req(DS_OP_DIV, 7, 16'hffff, 16'hffff));
    directed.push_back(make_req(DS_OP_DIV, 8, 16'h0001, 16'hffff));
    directed.push_back(make_req(DS_OP_DIV, 9, 16'h0000, 16'h0000));
    send_left = directed.size();
    wait_drained("directed requests");

    // Random traffic with gaps
    send_pct  = 40;
    send_left = 80;
    wait_drained("random requests");

    // Back to back, queue kept full
    send_pct  = 100;
    send_left = 24;
    wait_drained("back-to-back requests");

    // Response credits withheld
    withhold  = 1'b1;
    base      = received;
    send_left = 6;
    wait_responses(base + `DS_RSP_CREDITS, "responses before the stall");
    repeat (150) begin
      tick();
    end
    assert (received == base + `DS_RSP_CREDITS)
      else value_error($sformatf("%0d responses without credit", received - base));
    // One result in the hold stage and a full queue
    assert (req_credits == 0 && send_left == 1)
      else value_error($sformatf("stalled with %0d credits, %0d unsent",
                                 req_credits, send_left));
    withhold = 1'b0;
    wait_drained("responses after credit return");

    // Sender back at its full request credit
    assert (credit_pulses == sent_total)
      else value_error($sformatf("%0d credit pulses for %0d requests",
                                 credit_pulses, sent_total));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/divsqrt_pkg.sv
source/divsqrt_ctrl_pkg.sv
source/divsqrt_req_queue.sv
source/divsqrt_ctrl_fsm.sv
source/divsqrt_iter_counter.sv
source/divsqrt_datapath.sv
source/divsqrt_result_hold.sv
source/divsqrt_top.sv
testbench/divsqrt_chk.sv
testbench/divsqrt_tb.sv
